// File: project.f
+incdir+tests
hdl/usb_ram_pkg.sv
hdl/mem_port_if.sv
hdl/byte_dpram.sv
hdl/shared_ram.sv
hdl/mem_engine.sv
hdl/usb_mem_top.sv
tests/tb_usb_mem.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 -f project.f --top-module tb_usb_mem -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

out="$(./obj_dir/Vtb_usb_mem 2>&1)"
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1

// File: tests/tb_ref_model.svh
// Reference memory array with models of host byte-lane writes and the FILL, COPY and SUM commands.
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected memory contents with one entry per word.
usb_ram_pkg::word_t model_mem [WORDS];

// Host write merged lane by lane under the select bits.
function automatic void model_write(input int unsigned word, input usb_ram_pkg::word_t data,
		input usb_ram_pkg::sel_t sel);
	for (int i = 0; i < 4; i++) begin
		if (sel[i]) begin
			model_mem[word % WORDS][8*i +: 8] = data[8*i +: 8];
		end
	end
endfunction

// Runs one command on the model and returns the expected result word.
// Words go in order, so overlapping COPY ranges see earlier writes.
// FILL reports the pattern times the length modulo 2^32.
function automatic usb_ram_pkg::word_t model_cmd(input usb_ram_pkg::op_e op,
		input int unsigned src, input int unsigned dst, input int unsigned len,
		input usb_ram_pkg::word_t pattern);
	usb_ram_pkg::word_t acc;
	usb_ram_pkg::word_t w;
	acc = '0;
	for (int unsigned i = 0; i < len; i++) begin
		case (op)
			usb_ram_pkg::OP_FILL: begin
				model_mem[(dst + i) % WORDS] = pattern;
			end
			usb_ram_pkg::OP_COPY: begin
				w = model_mem[(src + i) % WORDS];
				model_mem[(dst + i) % WORDS] = w;
				acc += w;
			end
			default: begin
				acc += model_mem[(src + i) % WORDS];
			end
		endcase
	end
	if (op == usb_ram_pkg::OP_FILL) begin
		acc = pattern * len;
	end
	return acc;
endfunction

`endif

// File: tests/tb_usb_mem.sv
// Testbench top with clock, reset, random host and command stimulus, compare tasks and timeout.

module tb_usb_mem;

	localparam int unsigned ADDR_W   = 10;
	localparam int unsigned WORDS    = 2**ADDR_W;
	localparam int unsigned N_HOST   = 24;
	localparam int unsigned N_ROUNDS = 4;
	localparam int unsigned MAX_LEN  = 32;
	// Upper bounds on host accesses and command words over all phases.
	localparam int unsigned HOST_OPS  = 4 * N_HOST + 4 * N_ROUNDS * MAX_LEN + MAX_LEN;
	localparam int unsigned CMD_WORDS = WORDS + 4 * MAX_LEN * (N_ROUNDS + 1);
	// Three cycles per access, up to twelve per command for handshakes and stalls.
	localparam int unsigned LIMIT =
		2 * (3 * HOST_OPS + CMD_WORDS + 12 * (3 * N_ROUNDS + 5)) + 100;

	logic sys_clk_i, sys_rst_i;
	usb_ram_pkg::word_t wb_adr_i, wb_dat_i, wb_dat_o;
	usb_ram_pkg::sel_t wb_sel_i;
	logic wb_stb_i, wb_cyc_i, wb_we_i, wb_ack_o;
	logic cmd_valid_i, cmd_ready_o, res_valid_o, res_ready_i;
	usb_ram_pkg::op_e cmd_op_i, res_op_o;
	logic [ADDR_W-1:0] cmd_src_i, cmd_dst_i;
	usb_ram_pkg::len_t cmd_len_i;
	usb_ram_pkg::word_t cmd_pattern_i, res_sum_o;
	logic [31:0] seed = 32'h2a44_d56a;
	int unsigned cycles = 0;

	`include "tb_ref_model.svh"

	usb_mem_top #(.ADDR_W(ADDR_W)) i_usb_mem_top (.*);

	initial begin
		sys_clk_i = 1'b0;
		forever #4 sys_clk_i = ~sys_clk_i;
	end

	// Watchdog on the cycle budget.
	initial begin
		while (cycles < LIMIT) begin
			@(posedge sys_clk_i);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", LIMIT);
		$display("test failed");
		$fatal(1, "cycle limit reached");
	end

	// ########################################################################
	// Random numbers and checks.
	// ########################################################################

	// LCG step, high half folded in to hide the weak low bits.
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed ^ (seed >> 16);
	endfunction

	task automatic stop_with_error(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("test failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_word(input usb_ram_pkg::word_t got, input usb_ram_pkg::word_t exp,
			input int unsigned word);
		if (got !== exp) begin
			stop_with_error($sformatf("word %0d read 0x%08h, expected 0x%08h", word, got, exp));
		end
	endtask

	task automatic check_op(input usb_ram_pkg::op_e got, input usb_ram_pkg::op_e exp);
		if (got !== exp) begin
			stop_with_error($sformatf("result opcode %0d, expected %0d", got, exp));
		end
	endtask

	task automatic check_sum(input usb_ram_pkg::word_t got, input usb_ram_pkg::word_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("result sum 0x%08h, expected 0x%08h", got, exp));
		end
	endtask

	// ########################################################################
	// Bus and command drivers.
	// ########################################################################

	// One Wishbone classic cycle, ack expected at the second falling edge.
	task automatic wb_cycle(input logic we, input int unsigned word, input usb_ram_pkg::word_t data,
			input usb_ram_pkg::sel_t sel, output usb_ram_pkg::word_t rdata);
		int unsigned waited;
		waited = 0;
		@(posedge sys_clk_i);
		wb_stb_i <= 1'b1;
		wb_cyc_i <= 1'b1;
		wb_we_i  <= we;
		wb_adr_i <= word << 2;
		wb_dat_i <= data;
		wb_sel_i <= sel;
		do begin
			@(negedge sys_clk_i);
			waited++;
		end while (!wb_ack_o);
		if (waited != 2) begin
			stop_with_error("wb_ack_o did not follow the request by exactly one cycle");
		end
		rdata = wb_dat_o;
		@(posedge sys_clk_i);
		wb_stb_i <= 1'b0;
		wb_cyc_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic write_word(input int unsigned word, input usb_ram_pkg::word_t data,
			input usb_ram_pkg::sel_t sel);
		usb_ram_pkg::word_t unused;
		wb_cycle(1'b1, word, data, sel, unused);
		model_write(word, data, sel);
	endtask

	task automatic read_and_compare(input int unsigned word);
		usb_ram_pkg::word_t rd;
		wb_cycle(1'b0, word, '0, '0, rd);
		check_word(rd, model_mem[word % WORDS], word % WORDS);
	endtask

	// Issues a command, holds off the result for a number of cycles, checks and takes it.
	task automatic run_command(input usb_ram_pkg::op_e op, input int unsigned src,
			input int unsigned dst, input int unsigned len, input usb_ram_pkg::word_t pattern,
			input int unsigned stall);
		usb_ram_pkg::word_t exp_sum;
		usb_ram_pkg::word_t held;
		exp_sum = model_cmd(op, src, dst, len, pattern);
		@(posedge sys_clk_i);
		cmd_valid_i   <= 1'b1;
		cmd_op_i      <= op;
		cmd_src_i     <= src[ADDR_W-1:0];
		cmd_dst_i     <= dst[ADDR_W-1:0];
		cmd_len_i     <= len[15:0];
		cmd_pattern_i <= pattern;
		do begin
			@(negedge sys_clk_i);
		end while (!cmd_ready_o);
		// Transfer at this edge.
		@(posedge sys_clk_i);
		cmd_valid_i <= 1'b0;
		do begin
			@(negedge sys_clk_i);
		end while (!res_valid_o);
		held = res_sum_o;
		repeat (stall) begin
			@(negedge sys_clk_i);
			if (!res_valid_o || cmd_ready_o || res_sum_o !== held) begin
				stop_with_error("result channel changed while res_ready_i was low");
			end
		end
		check_op(res_op_o, op);
		check_sum(res_sum_o, exp_sum);
		@(posedge sys_clk_i);
		res_ready_i <= 1'b1;
		@(posedge sys_clk_i);
		res_ready_i <= 1'b0;
		@(negedge sys_clk_i);
		if (res_valid_o || !cmd_ready_o) begin
			stop_with_error("engine did not return to idle after the result was taken");
		end
	endtask

	// ########################################################################
	// Test sequence.
	// ########################################################################

	initial begin
		int unsigned base, src, len;
		int unsigned words [N_HOST];
		usb_ram_pkg::word_t pat;
		sys_rst_i     <= 1'b1;
		wb_adr_i      <= '0;
		wb_dat_i      <= '0;
		wb_sel_i      <= '0;
		wb_stb_i      <= 1'b0;
		wb_cyc_i      <= 1'b0;
		wb_we_i       <= 1'b0;
		cmd_valid_i   <= 1'b0;
		cmd_op_i      <= usb_ram_pkg::OP_FILL;
		cmd_src_i     <= '0;
		cmd_dst_i     <= '0;
		cmd_len_i     <= '0;
		cmd_pattern_i <= '0;
		res_ready_i   <= 1'b0;
		repeat (2) @(posedge sys_clk_i);
		sys_rst_i <= 1'b0;
		@(negedge sys_clk_i);
		if (wb_ack_o || res_valid_o || !cmd_ready_o) begin
			stop_with_error("outputs not in their idle state after reset");
		end
		// Whole memory gets a known value first.
		run_command(usb_ram_pkg::OP_FILL, 0, 0, WORDS, next_rand(), 2);
		// Byte-merged host writes, then reads of the same words.
		for (int i = 0; i < N_HOST; i++) begin
			words[i] = next_rand() % WORDS;
			write_word(words[i], next_rand(), usb_ram_pkg::sel_t'(next_rand()));
		end
		foreach (words[i]) begin
			read_and_compare(words[i]);
		end
		for (int r = 0; r < N_ROUNDS; r++) begin
			base = next_rand() % WORDS;
			len  = 1 + next_rand() % MAX_LEN;
			run_command(usb_ram_pkg::OP_FILL, 0, base, len, next_rand(), next_rand() % 8);
			for (int unsigned i = 0; i < len; i++) begin
				read_and_compare(base + i);
			end
			// COPY from a freshly written source range.
			src  = next_rand() % WORDS;
			base = next_rand() % WORDS;
			len  = 1 + next_rand() % MAX_LEN;
			for (int unsigned i = 0; i < len; i++) begin
				write_word(src + i, next_rand(), 4'hf);
			end
			run_command(usb_ram_pkg::OP_COPY, src, base, len, '0, next_rand() % 8);
			for (int unsigned i = 0; i < len; i++) begin
				read_and_compare(base + i);
			end
			src = next_rand() % WORDS;
			len = 1 + next_rand() % MAX_LEN;
			for (int unsigned i = 0; i < len; i++) begin
				write_word(src + i, next_rand(), usb_ram_pkg::sel_t'(next_rand()));
			end
			run_command(usb_ram_pkg::OP_SUM, src, 0, len, '0, next_rand() % 8);
		end
		run_command(usb_ram_pkg::OP_SUM, next_rand() % WORDS, 0, 0, '0, 3);
		// Engine in the lower half, host in the upper half, at the same time.
		src  = next_rand() % (WORDS / 2 - MAX_LEN);
		base = next_rand() % (WORDS / 2 - MAX_LEN);
		len  = 1 + next_rand() % MAX_LEN;
		pat  = next_rand();
		fork
			begin
				run_command(usb_ram_pkg::OP_FILL, 0, src, len, pat, 1);
				run_command(usb_ram_pkg::OP_COPY, src, base, len, '0, 4);
				run_command(usb_ram_pkg::OP_SUM, base, 0, len, '0, 0);
			end
			for (int i = 0; i < N_HOST; i++) begin
				int unsigned w;
				w = WORDS / 2 + next_rand() % (WORDS / 2);
				write_word(w, next_rand(), usb_ram_pkg::sel_t'(next_rand()));
				read_and_compare(w);
			end
		join
		for (int unsigned i = 0; i < len; i++) begin
			read_and_compare(base + i);
		end
		$display("test passed");
		$finish;
	end

endmodule

// File: hdl/usb_mem_top.sv
// Top level with the shared RAM and the memory engine, joined by one engine RAM port.

module usb_mem_top #(
	parameter int unsigned ADDR_W = 10
) (
	input  logic               sys_clk_i,
	input  logic               sys_rst_i,

	// Host Wishbone slave.
	input  usb_ram_pkg::word_t wb_adr_i,
	input  usb_ram_pkg::word_t wb_dat_i,
	output usb_ram_pkg::word_t wb_dat_o,
	input  usb_ram_pkg::sel_t  wb_sel_i,
	input  logic               wb_stb_i,
	input  logic               wb_cyc_i,
	input  logic               wb_we_i,
	output logic               wb_ack_o,

	// Command channel.
	input  logic               cmd_valid_i,
	output logic               cmd_ready_o,
	input  usb_ram_pkg::op_e   cmd_op_i,
	input  logic [ADDR_W-1:0]  cmd_src_i,
	input  logic [ADDR_W-1:0]  cmd_dst_i,
	input  usb_ram_pkg::len_t  cmd_len_i,
	input  usb_ram_pkg::word_t cmd_pattern_i,

	// Result channel.
	output logic               res_valid_o,
	input  logic               res_ready_i,
	output usb_ram_pkg::op_e   res_op_o,
	output usb_ram_pkg::word_t res_sum_o
);

	// Engine to RAM word port.
	mem_port_if #(.ADDR_W(ADDR_W)) eng_mem ();

	shared_ram #(
		.ADDR_W(ADDR_W)
	) i_shared_ram (
		.sys_clk_i(sys_clk_i),
		.sys_rst_i(sys_rst_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_sel_i (wb_sel_i),
		.wb_stb_i (wb_stb_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_we_i  (wb_we_i),
		.wb_ack_o (wb_ack_o),
		.eng_port (eng_mem.ram)
	);

	mem_engine #(
		.ADDR_W(ADDR_W)
	) i_mem_engine (
		.sys_clk_i    (sys_clk_i),
		.sys_rst_i    (sys_rst_i),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_ready_o  (cmd_ready_o),
		.cmd_op_i     (cmd_op_i),
		.cmd_src_i    (cmd_src_i),
		.cmd_dst_i    (cmd_dst_i),
		.cmd_len_i    (cmd_len_i),
		.cmd_pattern_i(cmd_pattern_i),
		.res_valid_o  (res_valid_o),
		.res_ready_i  (res_ready_i),
		.res_op_o     (res_op_o),
		.res_sum_o    (res_sum_o),
		.mem          (eng_mem.engine)
	);

endmodule

// File: hdl/mem_engine.sv
// Memory engine FSM that runs FILL, COPY and SUM commands over the engine RAM port.

module mem_engine #(
	parameter int unsigned ADDR_W = 10
) (
	input  logic               sys_clk_i,
	input  logic               sys_rst_i,

	// Command channel.
	input  logic               cmd_valid_i,
	output logic               cmd_ready_o,
	input  usb_ram_pkg::op_e   cmd_op_i,
	input  logic [ADDR_W-1:0]  cmd_src_i,
	input  logic [ADDR_W-1:0]  cmd_dst_i,
	input  usb_ram_pkg::len_t  cmd_len_i,
	input  usb_ram_pkg::word_t cmd_pattern_i,

	// Result channel.
	output logic               res_valid_o,
	input  logic               res_ready_i,
	output usb_ram_pkg::op_e   res_op_o,
	output usb_ram_pkg::word_t res_sum_o,

	// RAM word port.
	mem_port_if.engine         mem
);

	typedef enum logic [2:0] {
		IDLE,
		FILL,
		SUM_RUN,
		SUM_DRAIN,
		COPY_RD,
		COPY_WR,
		RESULT
	} state_e;

	state_e             state;
	// Read issued last cycle, data on mem.rdata now.
	logic               rd_pend;
	// Latched command and walking registers.
	usb_ram_pkg::op_e   op_q;
	logic [ADDR_W-1:0]  src_q;
	logic [ADDR_W-1:0]  dst_q;
	usb_ram_pkg::len_t  remain_q;
	usb_ram_pkg::word_t pattern_q;
	usb_ram_pkg::word_t sum_q;
	// Last word of the range in this cycle.
	logic               last;

	assign last = (remain_q == 16'd1);

	// ########################################################################
	// Control state.
	// ########################################################################

	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			state   <= IDLE;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= (state == SUM_RUN);
			case (state)
				IDLE: if (cmd_valid_i) begin
					if (cmd_len_i == '0) begin
						state <= RESULT;
					end else begin
						case (cmd_op_i)
							usb_ram_pkg::OP_FILL: state <= FILL;
							usb_ram_pkg::OP_COPY: state <= COPY_RD;
							default:              state <= SUM_RUN;
						endcase
					end
				end
				FILL:      if (last) state <= RESULT;
				SUM_RUN:   if (last) state <= SUM_DRAIN;
				// Last read word arrives here.
				SUM_DRAIN: state <= RESULT;
				COPY_RD:   state <= COPY_WR;
				COPY_WR:   state <= last ? RESULT : COPY_RD;
				RESULT:    if (res_ready_i) state <= IDLE;
				default:   state <= IDLE;
			endcase
		end
	end

	// ########################################################################
	// Command payload, addresses, count and checksum.
	// ########################################################################

	always_ff @(posedge sys_clk_i) begin
		if (state == IDLE && cmd_valid_i) begin
			op_q      <= cmd_op_i;
			src_q     <= cmd_src_i;
			dst_q     <= cmd_dst_i;
			remain_q  <= cmd_len_i;
			pattern_q <= cmd_pattern_i;
			sum_q     <= '0;
		end
		// Addresses wrap with the memory size.
		if (state == SUM_RUN || state == COPY_RD) begin
			src_q <= src_q + 1'b1;
		end
		if (state == FILL || state == COPY_WR) begin
			dst_q <= dst_q + 1'b1;
		end
		if (state == FILL || state == SUM_RUN || state == COPY_WR) begin
			remain_q <= remain_q - 1'b1;
		end
		// Pattern added once per word gives pattern times length.
		if (state == FILL) begin
			sum_q <= sum_q + pattern_q;
		end else if (rd_pend || state == COPY_WR) begin
			sum_q <= sum_q + mem.rdata;
		end
	end

	// ########################################################################
	// RAM port and handshakes.
	// ########################################################################

	// Writes use the destination, reads the source.
	// In COPY_WR the word read in COPY_RD is on rdata and goes straight out.
	always_comb begin
		mem.we    = (state == FILL) || (state == COPY_WR);
		mem.addr  = mem.we ? dst_q : src_q;
		mem.wdata = (state == FILL) ? pattern_q : mem.rdata;
	end

	assign cmd_ready_o = (state == IDLE);
	assign res_valid_o = (state == RESULT);
	assign res_op_o    = op_q;
	assign res_sum_o   = sum_q;

endmodule

// File: hdl/shared_ram.sv
// Wishbone slave acknowledge logic and four byte-lane RAMs shared with the engine port.

module shared_ram #(
	parameter int unsigned ADDR_W = 10
) (
	input  logic               sys_clk_i,
	input  logic               sys_rst_i,

	// Host Wishbone classic slave.
	input  usb_ram_pkg::word_t wb_adr_i,
	input  usb_ram_pkg::word_t wb_dat_i,
	output usb_ram_pkg::word_t wb_dat_o,
	input  usb_ram_pkg::sel_t  wb_sel_i,
	input  logic               wb_stb_i,
	input  logic               wb_cyc_i,
	input  logic               wb_we_i,
	output logic               wb_ack_o,

	// Engine side, whole words only.
	mem_port_if.ram            eng_port
);

	// New request seen this cycle.
	logic              wb_req;
	// Word address taken from the byte address.
	logic [ADDR_W-1:0] wb_word;
	// Per-lane read data from each side.
	logic [7:0]        wb_lane [usb_ram_pkg::LANES];
	logic [7:0]        eng_lane [usb_ram_pkg::LANES];

	// A request counts only while ack is low.
	// So a write lands once, in the first cycle of the request.
	assign wb_req  = wb_stb_i & wb_cyc_i & ~wb_ack_o;
	assign wb_word = wb_adr_i[ADDR_W+1:2];

	// ########################################################################
	// Acknowledge, one cycle after the request, for one cycle.
	// ########################################################################

	always_ff @(posedge sys_clk_i) begin
		if (sys_rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= wb_req;
		end
	end

	// ########################################################################
	// Byte lanes.
	// ########################################################################

	// Port A serves the host, gated per lane by its select bit.
	// Port B serves the engine, all lanes together.
	for (genvar i = 0; i < usb_ram_pkg::LANES; i++) begin : g_lane
		byte_dpram #(
			.ADDR_W(ADDR_W)
		) i_byte_dpram (
			.sys_clk_i(sys_clk_i),
			.a_addr_i (wb_word),
			.a_we_i   (wb_req & wb_we_i & wb_sel_i[i]),
			.a_din_i  (wb_dat_i[8*i +: 8]),
			.a_dout_o (wb_lane[i]),
			.b_addr_i (eng_port.addr),
			.b_we_i   (eng_port.we),
			.b_din_i  (eng_port.wdata[8*i +: 8]),
			.b_dout_o (eng_lane[i])
		);
	end

	// Reassemble the words.
	// Host data is valid while ack is high.
	always_comb begin
		for (int i = 0; i < usb_ram_pkg::LANES; i++) begin
			wb_dat_o[8*i +: 8]       = wb_lane[i];
			eng_port.rdata[8*i +: 8] = eng_lane[i];
		end
	end

endmodule

// File: hdl/byte_dpram.sv
// Byte-wide true dual-port RAM with a synchronous, read-before-write port on each side.

module byte_dpram #(
	parameter int unsigned ADDR_W = 10
) (
	input  logic              sys_clk_i,

	// Port A.
	input  logic [ADDR_W-1:0] a_addr_i,
	input  logic              a_we_i,
	input  logic [7:0]        a_din_i,
	output logic [7:0]        a_dout_o,

	// Port B.
	input  logic [ADDR_W-1:0] b_addr_i,
	input  logic              b_we_i,
	input  logic [7:0]        b_din_i,
	output logic [7:0]        b_dout_o
);

	// Storage, 2**ADDR_W bytes.
	logic [7:0] mem [2**ADDR_W];

	// Both ports share one clock, so a single process covers them.
	// Each port returns the old contents when it writes the same address.
	// Writes from both ports to one address in one cycle are undefined.
	always_ff @(posedge sys_clk_i) begin
		a_dout_o <= mem[a_addr_i];
		b_dout_o <= mem[b_addr_i];
		if (a_we_i) begin
			mem[a_addr_i] <= a_din_i;
		end
		if (b_we_i) begin
			mem[b_addr_i] <= b_din_i;
		end
	end

endmodule

// File: hdl/mem_port_if.sv
// Interface for one word-wide RAM port, with engine and RAM modports.

interface mem_port_if #(
	parameter int unsigned ADDR_W = 10
);

	// Word address, shared by reads and writes.
	logic [ADDR_W-1:0] addr;
	// Write strobe, always a whole word.
	logic we;
	// Write data.
	usb_ram_pkg::word_t wdata;
	// Read data, one cycle after the address.
	usb_ram_pkg::word_t rdata;

	// Side that issues accesses.
	modport engine (output addr, output we, output wdata, input rdata);

	// Side that holds the memory.
	modport ram (input addr, input we, input wdata, output rdata);

endinterface

// File: hdl/usb_ram_pkg.sv
// Package with the command opcode enum, the data word, length and byte-select types.

package usb_ram_pkg;

	// ########################################################################
	// Data types shared by the host port, the engine port and the results.
	// ########################################################################

	// One memory word as seen on both RAM ports.
	typedef logic [31:0] word_t;

	// Word count of an engine command.
	// Zero is legal and touches no memory.
	typedef logic [15:0] len_t;

	// Wishbone byte-lane selects, one bit per byte of word_t.
	typedef logic [3:0] sel_t;

	// Number of byte-wide RAM lanes behind one word.
	localparam int unsigned LANES = $bits(sel_t);

	// ########################################################################
	// Engine command opcodes.
	// ########################################################################

	// FILL writes the pattern word across the destination range.
	// COPY moves words from the source range to the destination range.
	// SUM adds the words of the source range into a checksum.
	typedef enum logic [1:0] {
		OP_FILL = 2'd0,
		OP_COPY = 2'd1,
		OP_SUM  = 2'd2
	} op_e;

endpackage
